// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_x86_length_decoder
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
verilog/x86_len_pkg.sv
verilog/prefix_scanner.sv
verilog/immediate_detector.sv
verilog/modrm_decoder.sv
verilog/length_adder.sv
verilog/decode_ctrl.sv
verilog/x86_length_decoder.sv
sim/x86_length_decoder_asserts.sv
sim/tb_x86_length_decoder.sv

// File: sim/tb_x86_length_decoder.sv
`timescale 1ns/1ps
`default_nettype none

// table-driven testbench for the two-stage x86 length decoder
module tb_x86_length_decoder;
    import x86_len_pkg::*;

    logic                            clk;
    logic                            reset;
    logic                            window_valid;
    logic [window_bytes-1:0][7:0]    window;
    logic                            out_valid;
    logic [len_width-1:0]            length;
    logic                            imm_present;
    imm_size_e                       imm_size;
    len_status_e                     status;
    logic [15:0]                     decoded_count;
    logic [15:0]                     fault_count;

    // expected values, one entry per window
    logic [127:0]         win_q[$];
    logic [len_width-1:0] len_q[$];
    logic                 imm_p_q[$];
    imm_size_e            imm_s_q[$];
    len_status_e          stat_q[$];
    // running number of non-ok entries up to and including each entry
    int                   fault_q[$];
    int                   exp_faults = 0;
    logic [31:0]          lcg_state;
    logic                 table_ready = 1'b0;

    // index and strobe delayed by the fixed two-cycle latency
    int   tx_idx = 0;
    int   idx_d1 = 0;
    int   idx_d2 = 0;
    logic valid_d1 = 1'b0;
    logic valid_d2 = 1'b0;
    int   rx_count = 0;

    x86_length_decoder dut_i (
        .clk           (clk),
        .reset         (reset),
        .window_valid  (window_valid),
        .window        (window),
        .out_valid     (out_valid),
        .length        (length),
        .imm_present   (imm_present),
        .imm_size      (imm_size),
        .status        (status),
        .decoded_count (decoded_count),
        .fault_count   (fault_count)
    );

    bind decode_ctrl x86_length_decoder_asserts asserts_i (
        .clk           (clk),
        .reset         (reset),
        .window_valid  (window_valid),
        .out_valid     (out_valid),
        .decoded_count (decoded_count),
        .fault_count   (fault_count)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // bytes holds the instruction with byte 0 as its most significant byte in use
    // everything behind the instruction is random filler
    task automatic add_entry(input logic [127:0] bytes, input int nbytes, input int exp_len,
                             input logic exp_imm, input imm_size_e exp_size,
                             input len_status_e exp_stat);
        logic [127:0] w;
        for (int i = 0; i < window_bytes; i++) begin
            if (i < nbytes) begin
                w[i*8 +: 8] = bytes[(nbytes-1-i)*8 +: 8];
            end else begin
                lcg_state = lcg_next(lcg_state);
                w[i*8 +: 8] = lcg_state[23:16];
            end
        end
        win_q.push_back(w);
        len_q.push_back(len_width'(exp_len));
        imm_p_q.push_back(exp_imm);
        imm_s_q.push_back(exp_size);
        stat_q.push_back(exp_stat);
        if (exp_stat != len_ok) begin
            exp_faults++;
        end
        fault_q.push_back(exp_faults);
    endtask

    task automatic build_table();
        logic [7:0] op;
        // ALU ops on AL and eAX step by 8 through the first quarter of the map
        for (int i = 0; i < 8; i++) begin
            op = 8'h04 + 8'(i * 8);
            add_entry(128'({op, 8'h7F}), 2, 2, 1'b1, imm_8, len_ok);
            add_entry(128'({op + 8'h01, 32'h78563412}), 5, 5, 1'b1, imm_32, len_ok);
        end
        // mov register with imm8 and with imm32
        for (int i = 0; i < 8; i++) begin
            op = 8'hB0 + 8'(i);
            add_entry(128'({op, 8'h5A}), 2, 2, 1'b1, imm_8, len_ok);
            add_entry(128'({op + 8'h08, 32'h78563412}), 5, 5, 1'b1, imm_32, len_ok);
        end
        add_entry(128'h6A_10, 2, 2, 1'b1, imm_8, len_ok);
        add_entry(128'hA8_01, 2, 2, 1'b1, imm_8, len_ok);
        add_entry(128'h6B_C0_07, 3, 3, 1'b1, imm_8, len_ok);
        add_entry(128'h80_C1_07, 3, 3, 1'b1, imm_8, len_ok);
        add_entry(128'h82_C1_07, 3, 3, 1'b1, imm_8, len_ok);
        add_entry(128'h83_C1_07, 3, 3, 1'b1, imm_8, len_ok);
        add_entry(128'hC0_E0_02, 3, 3, 1'b1, imm_8, len_ok);
        add_entry(128'hC1_E0_02, 3, 3, 1'b1, imm_8, len_ok);
        add_entry(128'hC6_C0_01, 3, 3, 1'b1, imm_8, len_ok);
        add_entry(128'hC2_08_00, 3, 3, 1'b1, imm_16, len_ok);
        add_entry(128'hCA_04_00, 3, 3, 1'b1, imm_16, len_ok);
        add_entry(128'h68_78_56_34_12, 5, 5, 1'b1, imm_32, len_ok);
        add_entry(128'hA9_78_56_34_12, 5, 5, 1'b1, imm_32, len_ok);
        add_entry(128'h69_C0_78_56_34_12, 6, 6, 1'b1, imm_32, len_ok);
        add_entry(128'h81_C0_78_56_34_12, 6, 6, 1'b1, imm_32, len_ok);
        add_entry(128'hC7_C0_78_56_34_12, 6, 6, 1'b1, imm_32, len_ok);
        // a few opcodes that carry no immediate
        add_entry(128'h90, 1, 1, 1'b0, imm_8, len_ok);
        add_entry(128'hC3, 1, 1, 1'b0, imm_8, len_ok);
        add_entry(128'h40, 1, 1, 1'b0, imm_8, len_ok);
        add_entry(128'h01_C8, 2, 2, 1'b0, imm_8, len_ok);
        add_entry(128'hFF_C0, 2, 2, 1'b0, imm_8, len_ok);
        // operand-size override shortens only the full-size immediates
        add_entry(128'h66_05_34_12, 4, 4, 1'b1, imm_16, len_ok);
        add_entry(128'h66_B8_34_12, 4, 4, 1'b1, imm_16, len_ok);
        add_entry(128'h66_68_34_12, 4, 4, 1'b1, imm_16, len_ok);
        add_entry(128'h66_81_C0_34_12, 5, 5, 1'b1, imm_16, len_ok);
        add_entry(128'h66_C7_C0_34_12, 5, 5, 1'b1, imm_16, len_ok);
        add_entry(128'h66_6A_10, 3, 3, 1'b1, imm_8, len_ok);
        add_entry(128'h66_83_C0_10, 4, 4, 1'b1, imm_8, len_ok);
        add_entry(128'h66_C2_08_00, 4, 4, 1'b1, imm_16, len_ok);
        add_entry(128'hF3_66_A9_34_12, 5, 5, 1'b1, imm_16, len_ok);
        // every mod and rm form through mov r32, r/m32
        add_entry(128'h8B_C1, 2, 2, 1'b0, imm_8, len_ok);
        add_entry(128'h8B_00, 2, 2, 1'b0, imm_8, len_ok);
        add_entry(128'h8B_05_44_33_22_11, 6, 6, 1'b0, imm_8, len_ok);
        add_entry(128'h8B_40_10, 3, 3, 1'b0, imm_8, len_ok);
        add_entry(128'h8B_80_44_33_22_11, 6, 6, 1'b0, imm_8, len_ok);
        add_entry(128'h8B_04_24, 3, 3, 1'b0, imm_8, len_ok);
        add_entry(128'h8B_04_25_44_33_22_11, 7, 7, 1'b0, imm_8, len_ok);
        add_entry(128'h8B_44_24_08, 4, 4, 1'b0, imm_8, len_ok);
        add_entry(128'h8B_84_24_44_33_22_11, 7, 7, 1'b0, imm_8, len_ok);
        add_entry(128'h8B_0C_8D_44_33_22_11, 7, 7, 1'b0, imm_8, len_ok);
        // two-byte opcodes behind the 0F escape
        add_entry(128'h0F_70_C1_08, 4, 4, 1'b1, imm_8, len_ok);
        add_entry(128'h0F_70_04_24_08, 5, 5, 1'b1, imm_8, len_ok);
        add_entry(128'h0F_70_44_24_10_08, 6, 6, 1'b1, imm_8, len_ok);
        add_entry(128'h0F_C8, 2, 2, 1'b0, imm_8, len_ok);
        add_entry(128'h0F_AF_C1, 3, 3, 1'b0, imm_8, len_ok);
        add_entry(128'h66_0F_70_C1_08, 5, 5, 1'b1, imm_8, len_ok);
        add_entry(128'h81_84_24_44_33_22_11_78_56_34_12, 11, 11, 1'b1, imm_32, len_ok);
        // three prefixes are the most that still decode, so 14 bytes is the longest ok form
        // and even four prefixes reach only 15, so no window can produce len_too_long
        add_entry(128'hF0_2E_3E_81_84_25_44_33_22_11_78_56_34_12, 14, 14, 1'b1, imm_32, len_ok);
        add_entry(128'h2E_3E_64_90, 4, 4, 1'b0, imm_8, len_ok);
        add_entry(128'hF0_F3_66_2E_90, 5, 5, 1'b0, imm_8, len_prefix_overflow);
        add_entry(128'h64_65_26_36_C3, 5, 5, 1'b0, imm_8, len_prefix_overflow);
    endtask

    task automatic check_length(input int idx, input logic [len_width-1:0] got,
                                input logic [len_width-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL length at entry %0d got 0x%0h expected 0x%0h",
                                idx, got, exp));
        end
    endtask

    // the size code only means something when an immediate is present
    task automatic check_imm(input int idx, input logic got_p, input imm_size_e got_s,
                             input logic exp_p, input imm_size_e exp_s);
        if (got_p !== exp_p) begin
            abort_run($sformatf("FAIL imm_present at entry %0d got 0x%0h expected 0x%0h",
                                idx, got_p, exp_p));
        end
        if (exp_p && got_s !== exp_s) begin
            abort_run($sformatf("FAIL imm_size at entry %0d got 0x%0h expected 0x%0h",
                                idx, got_s, exp_s));
        end
    endtask

    task automatic check_status(input int idx, input len_status_e got, input len_status_e exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL status at entry %0d got 0x%0h expected 0x%0h",
                                idx, got, exp));
        end
    endtask

    task automatic check_count(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // follow each strobe through the two pipeline stages
    always @(posedge clk) begin
        idx_d1   <= tx_idx;
        idx_d2   <= idx_d1;
        valid_d1 <= window_valid;
        valid_d2 <= valid_d1;
    end

    // outputs are sampled half a cycle after the edge that produced them
    always @(negedge clk) begin
        if (!reset) begin
            if (out_valid !== valid_d2) begin
                abort_run("out_valid did not follow the window strobe by two cycles");
            end
            if (out_valid === 1'b1) begin
                check_length(idx_d2, length, len_q[idx_d2]);
                check_imm(idx_d2, imm_present, imm_size, imm_p_q[idx_d2], imm_s_q[idx_d2]);
                check_status(idx_d2, status, stat_q[idx_d2]);
                // the counters already include the result on show
                check_count("decoded_count", decoded_count, 16'(idx_d2 + 1));
                check_count("fault_count", fault_count, 16'(fault_q[idx_d2]));
                rx_count++;
            end
        end
    end

    initial begin
        wait (table_ready);
        repeat (5 + win_q.size() + 20) @(posedge clk);
        abort_run("watchdog expired before every result came back");
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        window_valid = 1'b0;
        window       = '0;
        lcg_state    = 32'haf6e_9d03;
        build_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        // windows go in back to back, one per cycle
        for (int i = 0; i < win_q.size(); i++) begin
            @(posedge clk);
            window_valid <= 1'b1;
            window       <= win_q[i];
            tx_idx       <= i;
        end
        @(posedge clk);
        window_valid <= 1'b0;
        wait (rx_count == win_q.size());
        @(negedge clk);
        check_count("decoded_count", decoded_count, 16'(win_q.size()));
        check_count("fault_count", fault_count, 16'(exp_faults));
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/x86_length_decoder_asserts.sv
`timescale 1ns/1ps
`default_nettype none

// checks on the valid pipeline and the result counters of decode_ctrl
module x86_length_decoder_asserts (
    input logic        clk,
    input logic        reset,
    input logic        window_valid,
    input logic        out_valid,
    input logic [15:0] decoded_count,
    input logic [15:0] fault_count
);
    logic count_wrapped;

    // once decoded_count reaches its top value the two counters can cross
    always_ff @(posedge clk) begin
        if (reset) begin
            count_wrapped <= 1'b0;
        end else if (decoded_count == 16'hFFFF) begin
            count_wrapped <= 1'b1;
        end
    end

    // two register stages sit between the strobe and the result
    valid_latency: assert property (@(posedge clk) disable iff (reset)
        out_valid == $past(window_valid, 2))
        else $error("out_valid does not follow window_valid by two cycles");

    reset_clears_valid: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high while in reset");

    faults_within_decoded: assert property (@(posedge clk) disable iff (reset)
        !count_wrapped |-> fault_count <= decoded_count)
        else $error("fault_count exceeds decoded_count");

endmodule

`default_nettype wire

// File: verilog/decode_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// valid pipeline, status classification and result counters
module decode_ctrl (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                window_valid,
    input  logic                                prefix_overflow,
    input  logic [x86_len_pkg::len_width-1:0]   sum,
    output logic                                load_s1,
    output logic                                load_s2,
    output logic                                out_valid,
    output x86_len_pkg::len_status_e            status,
    output logic [15:0]                         decoded_count,
    output logic [15:0]                         fault_count
);
    import x86_len_pkg::*;

    logic        valid_s1;
    logic        valid_s2;
    len_status_e status_c;

    // no back-pressure, so each stage loads whenever its input is valid
    assign load_s1   = window_valid;
    assign load_s2   = valid_s1;
    assign out_valid = valid_s2;

    // overflow wins, since the sum is meaningless without a real opcode
    always_comb begin
        if (prefix_overflow) begin
            status_c = len_prefix_overflow;
        end else if (sum > len_width'(max_length)) begin
            status_c = len_too_long;
        end else begin
            status_c = len_ok;
        end
    end

    // counters step as the result enters stage 2, so they already include
    // the instruction shown while out_valid is high
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_s1      <= 1'b0;
            valid_s2      <= 1'b0;
            decoded_count <= '0;
            fault_count   <= '0;
        end else begin
            valid_s1 <= window_valid;
            valid_s2 <= valid_s1;
            if (load_s2) begin
                decoded_count <= decoded_count + 16'd1;
                if (status_c != len_ok) begin
                    fault_count <= fault_count + 16'd1;
                end
            end
        end
    end

    // status travels alongside length in stage 2
    always_ff @(posedge clk) begin
        if (load_s2) begin
            status <= status_c;
        end
    end

endmodule

`default_nettype wire

// File: verilog/immediate_detector.sv
`timescale 1ns/1ps
`default_nettype none

// decides whether the opcode carries an immediate and how wide it is
module immediate_detector (
    input  logic                   [15:0] opcode,
    input  logic                          operand_override,
    output logic                          imm_present,
    output x86_len_pkg::imm_size_e        imm_size
);
    import x86_len_pkg::*;

    logic two_byte;

    // the scanner leaves the high half zero for one-byte opcodes
    assign two_byte = (opcode[15:8] == 8'h0F);

    always_comb begin
        imm_present = 1'b0;
        imm_size    = imm_8;
        if (two_byte) begin
            // pshufw style 0F 70 is the only two-byte opcode with an immediate here
            if (opcode[7:0] == 8'h70) begin
                imm_present = 1'b1;
                imm_size    = imm_8;
            end
        end else begin
            case (opcode[7:0]) inside
                // ALU ops on AL, push imm8, imul imm8, group 1 imm8,
                // test AL, mov r8 imm8, shift groups and mov r/m8 imm8
                8'h04, 8'h0C, 8'h14, 8'h1C,
                8'h24, 8'h2C, 8'h34, 8'h3C,
                8'h6A, 8'h6B, 8'h80, 8'h82, 8'h83, 8'hA8,
                [8'hB0:8'hB7],
                8'hC0, 8'hC1, 8'hC6: begin
                    imm_present = 1'b1;
                    imm_size    = imm_8;
                end
                // ret imm16 near and far, always 16 bits regardless of 66
                8'hC2, 8'hCA: begin
                    imm_present = 1'b1;
                    imm_size    = imm_16;
                end
                // full operand-size immediates on eAX, push, imul, group 1,
                // test eAX, mov r32 and mov r/m32
                8'h05, 8'h0D, 8'h15, 8'h1D,
                8'h25, 8'h2D, 8'h35, 8'h3D,
                8'h68, 8'h69, 8'h81, 8'hA9,
                [8'hB8:8'hBF],
                8'hC7: begin
                    imm_present = 1'b1;
                    // operand-size override drops these to 16 bits
                    if (operand_override) begin
                        imm_size = imm_16;
                    end else begin
                        imm_size = imm_32;
                    end
                end
                default: begin
                    imm_present = 1'b0;
                    imm_size    = imm_8;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/length_adder.sv
`timescale 1ns/1ps
`default_nettype none

// stage 2, adds up every field of the instruction and registers the result
module length_adder (
    input  logic                                clk,
    input  logic                                load,
    input  logic [2:0]                          prefix_count,
    input  logic                                escape_0f,
    input  logic                                modrm_present,
    input  logic [2:0]                          addr_bytes,
    input  logic                                imm_present_in,
    input  x86_len_pkg::imm_size_e              imm_size_in,
    output logic [x86_len_pkg::len_width-1:0]   sum,
    output logic [x86_len_pkg::len_width-1:0]   length,
    output logic                                imm_present,
    output x86_len_pkg::imm_size_e              imm_size
);
    import x86_len_pkg::*;

    logic [2:0] imm_bytes;

    // size code to byte count, nothing when there is no immediate
    always_comb begin
        case (imm_size_in)
            imm_16:  imm_bytes = 3'd2;
            imm_32:  imm_bytes = 3'd4;
            default: imm_bytes = 3'd1;
        endcase
        if (!imm_present_in) begin
            imm_bytes = 3'd0;
        end
    end

    // one opcode byte always, a second one behind the 0F escape
    // the unregistered sum also feeds the status check in the control block
    assign sum = len_width'(prefix_count) + len_width'(1) + len_width'(escape_0f)
               + len_width'(modrm_present) + len_width'(addr_bytes)
               + len_width'(imm_bytes);

    always_ff @(posedge clk) begin
        if (load) begin
            length      <= sum;
            imm_present <= imm_present_in;
            imm_size    <= imm_size_in;
        end
    end

endmodule

`default_nettype wire

// File: verilog/modrm_decoder.sv
`timescale 1ns/1ps
`default_nettype none

// finds the ModRM byte and counts the SIB and displacement bytes behind it
module modrm_decoder (
    input  logic [15:0] opcode,
    input  logic [7:0]  modrm,
    input  logic [7:0]  sib,
    output logic        modrm_present,
    output logic [2:0]  addr_bytes
);

    logic       two_byte;
    logic [1:0] mod_f;
    logic [2:0] rm_f;
    logic       has_sib;
    logic [2:0] disp_bytes;

    assign two_byte = (opcode[15:8] == 8'h0F);
    assign mod_f    = modrm[7:6];
    assign rm_f     = modrm[2:0];

    // which opcodes take a ModRM byte
    always_comb begin
        if (two_byte) begin
            // jcc near, push/pop fs and gs, and bswap have no ModRM
            case (opcode[7:0]) inside
                [8'h80:8'h8F], 8'hA0, 8'hA1, 8'hA8, 8'hA9,
                [8'hC8:8'hCF]: modrm_present = 1'b0;
                default:       modrm_present = 1'b1;
            endcase
        end else begin
            case (opcode[7:0]) inside
                // bound, arpl, imul, group 1, mov, lea, pop r/m,
                // shifts, les/lds, mov imm, x87 escapes and inc/dec groups
                8'h62, 8'h63, 8'h69, 8'h6B,
                [8'h80:8'h8F],
                8'hC0, 8'hC1, [8'hC4:8'hC7],
                [8'hD0:8'hD3], [8'hD8:8'hDF],
                8'hFE, 8'hFF:  modrm_present = 1'b1;
                // the classic ALU block uses ModRM when bit 2 is clear
                default:       modrm_present = (opcode[7:6] == 2'b00) && !opcode[2];
            endcase
        end
    end

    // rm 100 outside register mode brings in a SIB byte
    assign has_sib = (mod_f != 2'b11) && (rm_f == 3'b100);

    // displacement size, 32-bit addressing only
    always_comb begin
        case (mod_f)
            2'b01: disp_bytes = 3'd1;
            2'b10: disp_bytes = 3'd4;
            2'b00: begin
                // rm 101 is disp32 without a base, as is a SIB base of 101
                if (rm_f == 3'b101 || (has_sib && sib[2:0] == 3'b101)) begin
                    disp_bytes = 3'd4;
                end else begin
                    disp_bytes = 3'd0;
                end
            end
            default: disp_bytes = 3'd0;
        endcase
    end

    // without a ModRM byte there are no addressing bytes at all
    assign addr_bytes = modrm_present ? (disp_bytes + {2'b00, has_sib}) : 3'd0;

endmodule

`default_nettype wire

// File: verilog/prefix_scanner.sv
`timescale 1ns/1ps
`default_nettype none

// stage 1, finds the legacy prefixes and lines up the opcode bytes
module prefix_scanner (
    input  logic                                  clk,
    input  logic                                  load,
    input  logic [x86_len_pkg::window_bytes-1:0][7:0] window,
    output logic [2:0]                            prefix_count,
    output logic                                  operand_override,
    output logic                                  escape_0f,
    output logic [15:0]                           opcode,
    output logic [7:0]                            modrm,
    output logic [7:0]                            sib,
    output logic                                  prefix_overflow
);
    import x86_len_pkg::*;

    logic [2:0] count_c;
    logic       run_c;
    logic       override_c;
    logic [3:0] op_idx;
    logic       esc_c;
    logic [3:0] low_idx;
    logic [3:0] body_idx;

    // legacy prefixes that are accepted, 67 is not among them
    function automatic logic is_prefix(input logic [7:0] b);
        case (b)
            8'h66, 8'hF0, 8'hF2, 8'hF3,
            8'h26, 8'h2E, 8'h36, 8'h3E, 8'h64, 8'h65: is_prefix = 1'b1;
            default:                                  is_prefix = 1'b0;
        endcase
    endfunction

    // count the unbroken run of prefixes at the start of the window
    // the first non-prefix byte ends the run
    always_comb begin
        count_c    = '0;
        run_c      = 1'b1;
        override_c = 1'b0;
        for (int i = 0; i < max_prefixes; i++) begin
            if (run_c && is_prefix(window[i])) begin
                count_c = count_c + 3'd1;
                // 66 anywhere in the run shortens full-size immediates
                if (window[i] == 8'h66) begin
                    override_c = 1'b1;
                end
            end else begin
                run_c = 1'b0;
            end
        end
    end

    // the opcode byte follows the prefixes directly
    assign op_idx   = {1'b0, count_c};
    assign esc_c    = (window[op_idx] == 8'h0F);
    // with the 0F escape the real opcode is one byte further on
    assign low_idx  = op_idx + {3'b000, esc_c};
    assign body_idx = low_idx + 4'd1;

    // opcode, ModRM and SIB candidates are captured together with the prefix info
    always_ff @(posedge clk) begin
        if (load) begin
            prefix_count     <= count_c;
            operand_override <= override_c;
            escape_0f        <= esc_c;
            opcode           <= esc_c ? {8'h0F, window[low_idx]} : {8'h00, window[op_idx]};
            modrm            <= window[body_idx];
            sib              <= window[body_idx + 4'd1];
            prefix_overflow  <= (count_c == 3'(max_prefixes));
        end
    end

endmodule

`default_nettype wire

// File: verilog/x86_len_pkg.sv
`default_nettype none

// shared sizes and encodings for the x86 length-decode front end
package x86_len_pkg;

    // bytes in one fetch window, byte 0 sits in the low bits
    localparam int unsigned window_bytes = 16;

    // stage 1 only looks at this many leading bytes for prefixes
    localparam int unsigned max_prefixes = 4;

    // architectural limit on the length of one instruction
    localparam int unsigned max_length = 15;

    // wide enough for the worst case sum of 16 bytes
    localparam int unsigned len_width = 5;

    // immediate size code
    // full-size immediates switch between imm_32 and imm_16 on the 66 prefix
    typedef enum logic [1:0] {
        imm_8  = 2'b00,
        imm_16 = 2'b01,
        imm_32 = 2'b10
    } imm_size_e;

    // result status for one decoded instruction
    // overflow means every examined byte was a prefix, so the opcode is unknown
    typedef enum logic [1:0] {
        len_ok              = 2'b00,
        len_prefix_overflow = 2'b01,
        len_too_long        = 2'b10
    } len_status_e;

endpackage

`default_nettype wire

// File: verilog/x86_length_decoder.sv
`timescale 1ns/1ps
`default_nettype none

// two-stage length decoder for the instruction at byte 0 of a fetch window
module x86_length_decoder (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  window_valid,
    input  logic [x86_len_pkg::window_bytes-1:0][7:0] window,
    output logic                                  out_valid,
    output logic [x86_len_pkg::len_width-1:0]     length,
    output logic                                  imm_present,
    output x86_len_pkg::imm_size_e                imm_size,
    output x86_len_pkg::len_status_e              status,
    output logic [15:0]                           decoded_count,
    output logic [15:0]                           fault_count
);
    import x86_len_pkg::*;

    logic                 load_s1;
    logic                 load_s2;
    logic [2:0]           prefix_count;
    logic                 operand_override;
    logic                 escape_0f;
    logic [15:0]          opcode;
    logic [7:0]           modrm;
    logic [7:0]           sib;
    logic                 prefix_overflow;
    logic                 imm_present_c;
    imm_size_e            imm_size_c;
    logic                 modrm_present;
    logic [2:0]           addr_bytes;
    logic [len_width-1:0] sum;

    decode_ctrl decode_ctrl_i (
        .clk             (clk),
        .reset           (reset),
        .window_valid    (window_valid),
        .prefix_overflow (prefix_overflow),
        .sum             (sum),
        .load_s1         (load_s1),
        .load_s2         (load_s2),
        .out_valid       (out_valid),
        .status          (status),
        .decoded_count   (decoded_count),
        .fault_count     (fault_count)
    );

    prefix_scanner prefix_scanner_i (
        .clk              (clk),
        .load             (load_s1),
        .window           (window),
        .prefix_count     (prefix_count),
        .operand_override (operand_override),
        .escape_0f        (escape_0f),
        .opcode           (opcode),
        .modrm            (modrm),
        .sib              (sib),
        .prefix_overflow  (prefix_overflow)
    );

    // both tables work on the stage 1 registers within the same cycle
    immediate_detector immediate_detector_i (
        .opcode           (opcode),
        .operand_override (operand_override),
        .imm_present      (imm_present_c),
        .imm_size         (imm_size_c)
    );

    modrm_decoder modrm_decoder_i (
        .opcode        (opcode),
        .modrm         (modrm),
        .sib           (sib),
        .modrm_present (modrm_present),
        .addr_bytes    (addr_bytes)
    );

    length_adder length_adder_i (
        .clk            (clk),
        .load           (load_s2),
        .prefix_count   (prefix_count),
        .escape_0f      (escape_0f),
        .modrm_present  (modrm_present),
        .addr_bytes     (addr_bytes),
        .imm_present_in (imm_present_c),
        .imm_size_in    (imm_size_c),
        .sum            (sum),
        .length         (length),
        .imm_present    (imm_present),
        .imm_size       (imm_size)
    );

endmodule

`default_nettype wire
